// ==== tb.f ====
+incdir+include
source/lsu_pkg.sv
source/lsu_align.sv
source/lsu_issue.sv
source/lsu_dmem.sv
source/lsu_top.sv
verif/lsu_checker.sv
verif/lsu_asserts.sv
verif/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - include_dirs:
      - include
    files:
      - source/lsu_pkg.sv
      - source/lsu_align.sv
      - source/lsu_issue.sv
      - source/lsu_dmem.sv
      - source/lsu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/lsu_checker.sv
      - verif/lsu_asserts.sv
      - verif/lsu_tb.sv

// ==== verif/lsu_tb.sv ====
/* load/store unit testbench
   clock, reset, seeded random four-phase commands and watchdog */

`default_nettype none

`include "lsu_params.svh"

module lsu_tb;

  import lsu_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 10;
  localparam int N_INIT      = 16;     // words in the window
  localparam int N_RAND      = 400;
  localparam int CYC_PER_CMD = 20;     // generous per command
  localparam int WIN_BASE    = 'h100;  // byte address of the window
  localparam int TIMEOUT     = (RST_CYCLES + (N_INIT + N_RAND) * CYC_PER_CMD) * CLK_PERIOD;

  localparam f3_t LOAD_CODES  [5] = '{LB, LH, LW, LBU, LHU};
  localparam f3_t STORE_CODES [3] = '{SB, SH, SW};

  logic  clk;
  logic  rst;
  logic  cmd_req;
  logic  cmd_we;
  f3_t   cmd_f3;
  adr_t  cmd_adr;
  word_t cmd_wdt;
  logic  cmd_ack;
  word_t rsp_rdt;
  logic  rsp_err;
  int    errors;

  lsu_top dut (
    .clk, .rst,
    .cmd_req, .cmd_we, .cmd_f3, .cmd_adr, .cmd_wdt,
    .cmd_ack, .rsp_rdt, .rsp_err
  );

  lsu_checker chk (
    .clk, .rst,
    .cmd_req, .cmd_we, .cmd_f3, .cmd_adr, .cmd_wdt,
    .cmd_ack, .rsp_rdt, .rsp_err
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // four-phase driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic issue_cmd(input logic st, input f3_t code, input adr_t a, input word_t d);
    @(posedge clk);
    cmd_req <= 1'b1;
    cmd_we  <= st;
    cmd_f3  <= code;
    cmd_adr <= a;
    cmd_wdt <= d;
    do @(posedge clk); while (!cmd_ack);  // response valid
    cmd_req <= 1'b0;
    do @(posedge clk); while (cmd_ack);   // unit released
  endtask

  task automatic random_cmd();
    logic st;
    f3_t  code;
    adr_t a;
    int   pick;
    st   = ($urandom % 2) == 1;
    pick = $urandom % 16;
    if (pick >= 13) code = f3_t'($urandom % 8);  // any code, often illegal
    else if (st) code = STORE_CODES[pick % 3];
    else code = LOAD_CODES[pick % 5];
    if ($urandom % 8 != 0) a = WIN_BASE + $urandom % (4 * N_INIT);
    else a = $urandom % (1 << `LSU_AW);  // anywhere in memory
    if ($urandom % 2 == 0) a = a & ~adr_t'(3);  // aligned for every size
    issue_cmd(st, code, a, $urandom);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(66));  // once per run
    rst     = 1'b1;
    cmd_req = 1'b0;
    cmd_we  = 1'b0;
    cmd_f3  = '0;
    cmd_adr = '0;
    cmd_wdt = '0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < N_INIT; i++) begin
      issue_cmd(1'b1, SW, adr_t'(WIN_BASE + 4 * i), $urandom);  // known window
    end
    repeat (N_RAND) random_cmd();
    repeat (4) @(posedge clk);
    errors = chk.final_report(dut.u_asserts.n_fail);
    if (errors == 0) $display("=== PASS ===");
    else $display("=== FAIL ===");
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT);
    $display("timeout: run not finished after %0d time units, a response is missing",
             TIMEOUT);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/lsu_asserts.sv ====
/* protocol assertions for the load/store unit
   data bus hold rule, rejected accesses, host handshake */

`default_nettype none

module lsu_asserts (
  input  logic           clk,
  input  logic           rst,
  input  logic           cmd_req,
  input  logic           cmd_ack,
  input  logic           ls_req,
  input  logic           ls_wen,
  input  logic           ls_ack,
  input  logic           mal,
  input  lsu_pkg::ben_t  ls_ben
);

  int n_fail = 0;  // failed assertions

  // request held until acknowledged
  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    ls_req && !ls_ack |=> ls_req)
    else begin
      $error("ls_req dropped before ls_ack");
      n_fail++;
    end

  // rejected accesses never reach the bus
  a_no_mal_req: assert property (@(posedge clk) disable iff (rst)
    ls_req |-> !mal)
    else begin
      $error("ls_req high with mal set");
      n_fail++;
    end

  a_wr_ben: assert property (@(posedge clk) disable iff (rst)
    ls_req && ls_wen |-> ls_ben != '0)
    else begin
      $error("write request with no byte enable");
      n_fail++;
    end

  // four-phase host side
  a_ack_req: assert property (@(posedge clk) disable iff (rst)
    $rose(cmd_ack) |-> cmd_req)
    else begin
      $error("cmd_ack rose without cmd_req");
      n_fail++;
    end

endmodule

bind lsu_top lsu_asserts u_asserts (
  .clk, .rst, .cmd_req, .cmd_ack, .ls_req, .ls_wen, .ls_ack, .mal, .ls_ben
);

`default_nettype wire

// ==== verif/lsu_checker.sv ====
/* load/store unit response checker
   byte array model of the data memory, compares every host response */

`default_nettype none

`include "lsu_params.svh"

module lsu_checker (
  input  logic             clk,
  input  logic             rst,
  // host port, watched only
  input  logic             cmd_req,
  input  logic             cmd_we,
  input  lsu_pkg::f3_t     cmd_f3,
  input  lsu_pkg::word_t   cmd_adr,
  input  lsu_pkg::word_t   cmd_wdt,
  input  logic             cmd_ack,
  input  lsu_pkg::word_t   rsp_rdt,
  input  logic             rsp_err
);

  import lsu_pkg::*;

  localparam int MEM_BYTES = 2**`LSU_AW;

  logic [7:0] model [MEM_BYTES];  // starts unknown, like the memory
  logic       req_q;              // previous cycle
  logic       ack_q;
  int         errors;
  int         n_cmd;              // cmd_req rises
  int         n_rsp;              // cmd_ack rises

  initial begin
    errors = 0;
    n_cmd  = 0;
    n_rsp  = 0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // access rules
  ////////////////////////////////////////////////////////////////////////////

  // bytes moved, 0 marks a code rv32 does not have
  function automatic int access_size(input logic st, input f3_t code);
    if (st) begin
      case (code)
        SB:      return 1;
        SH:      return 2;
        SW:      return 4;
        default: return 0;
      endcase
    end
    case (code)
      LB, LBU: return 1;
      LH, LHU: return 2;
      LW:      return 4;
      default: return 0;
    endcase
  endfunction

  // little endian gather, then extend by signedness
  function automatic word_t load_value(input f3_t code, input int a);
    word_t v;
    int    n;
    n = access_size(1'b0, code);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = model[a + i];
    end
    if (code == LB) v = {{24{v[7]}}, v[7:0]};
    else if (code == LH) v = {{16{v[15]}}, v[15:0]};
    return v;
  endfunction

  task automatic check_response();
    int    n;
    int    a;
    logic  ok;
    word_t exp;
    n  = access_size(cmd_we, cmd_f3);
    a  = int'(cmd_adr[`LSU_AW-1:0]);  // memory sees the low bits only
    ok = (n != 0) && (a % n == 0);
    if (rsp_err !== ~ok) begin
      $display("** Error @ %0t: we %0b f3 %0d adr %h: rsp_err %b, expected %b",
               $time, cmd_we, cmd_f3, cmd_adr, rsp_err, ~ok);
      errors++;
    end
    if (!ok) begin
      if (rsp_rdt !== '0) begin
        $display("** Error @ %0t: rejected f3 %0d adr %h: rsp_rdt %h, expected 0",
                 $time, cmd_f3, cmd_adr, rsp_rdt);
        errors++;
      end
    end else if (cmd_we) begin
      for (int i = 0; i < n; i++) begin
        model[a + i] = cmd_wdt[8*i +: 8];  // only lanes of the access
      end
    end else begin
      exp = load_value(cmd_f3, a);
      if (rsp_rdt !== exp) begin
        $display("** Error @ %0t: load f3 %0d adr %h: rsp_rdt %h, expected %h",
                 $time, cmd_f3, cmd_adr, rsp_rdt, exp);
        errors++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // handshake watch
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      req_q <= 1'b0;
      ack_q <= 1'b0;
    end else begin
      req_q <= cmd_req;
      ack_q <= cmd_ack;
      if (cmd_req && !req_q) n_cmd++;
      if (cmd_ack && !ack_q) begin
        n_rsp++;
        if (!cmd_req) begin
          $display("protocol problem at %0t: cmd_ack rose without cmd_req", $time);
          errors++;
        end else begin
          check_response();
        end
      end
      if (!cmd_ack && ack_q && cmd_req) begin
        $display("protocol problem at %0t: cmd_ack dropped while cmd_req high", $time);
        errors++;
      end
    end
  end

  // closing count line, returns the total error count
  function int final_report(input int n_assert);
    if (n_rsp != n_cmd) begin
      $display("missing response: %0d commands issued but %0d responses seen",
               n_cmd, n_rsp);
      errors++;
    end
    errors += n_assert;  // protocol assertion failures
    $display("checker: %0d commands, %0d responses, %0d assertion failures, %0d errors",
             n_cmd, n_rsp, n_assert, errors);
    return errors;
  endfunction

endmodule

`default_nettype wire

// ==== source/lsu_top.sv ====
/* load/store unit top level
   sequencer, alignment block and data memory */

`default_nettype none

`include "lsu_params.svh"

module lsu_top (
  input  logic             clk,
  input  logic             rst,
  // host command port, four-phase
  input  logic             cmd_req,
  input  logic             cmd_we,
  input  lsu_pkg::f3_t     cmd_f3,
  input  lsu_pkg::adr_t    cmd_adr,
  input  lsu_pkg::word_t   cmd_wdt,
  output logic             cmd_ack,
  output lsu_pkg::word_t   rsp_rdt,
  output logic             rsp_err
);

  import lsu_pkg::*;

  // sequencer to alignment block
  logic  en, we, mal, dly;
  f3_t   f3;
  adr_t  adr;
  word_t wdt, rdt;

  // data bus
  logic               ls_req, ls_wen, ls_ack;
  logic [`LSU_AW-1:0] ls_adr;
  ben_t               ls_ben;
  word_t              ls_wdt, ls_rdt;

  lsu_issue u_issue (
    .clk, .rst,
    .cmd_req, .cmd_we, .cmd_f3, .cmd_adr, .cmd_wdt,
    .cmd_ack, .rsp_rdt, .rsp_err,
    .en, .we, .f3, .adr, .wdt,
    .mal, .dly, .rdt,
    .ls_req, .ls_ack
  );

  lsu_align u_align (
    .clk, .rst,
    .en, .we, .f3, .adr, .wdt,
    .rdt, .mal, .dly,
    .ls_req, .ls_wen, .ls_adr, .ls_ben, .ls_wdt, .ls_rdt, .ls_ack
  );

  lsu_dmem #(
    .WAIT (`LSU_DMEM_WAIT),
    .AW   (`LSU_AW)
  ) u_dmem (
    .clk, .rst,
    .ls_req, .ls_wen, .ls_adr, .ls_ben, .ls_wdt, .ls_rdt, .ls_ack
  );

endmodule

`default_nettype wire

// ==== source/lsu_dmem.sv ====
/* byte-enabled data memory on the req/ack bus
   ack after programmable wait states, registered read data */

`default_nettype none

`include "lsu_params.svh"

module lsu_dmem #(
  parameter int unsigned WAIT = `LSU_DMEM_WAIT,  // idle cycles before ack
  parameter int unsigned AW   = `LSU_AW          // byte address bits
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             ls_req,
  input  logic             ls_wen,
  input  logic [AW-1:0]    ls_adr,
  input  lsu_pkg::ben_t    ls_ben,
  input  lsu_pkg::word_t   ls_wdt,
  output lsu_pkg::word_t   ls_rdt,
  output logic             ls_ack
);

  import lsu_pkg::*;

  localparam int unsigned BW = $bits(ben_t);          // byte lanes
  localparam int unsigned WW = $clog2(BW);            // byte offset bits
  localparam int unsigned CW = (WAIT > 0) ? $clog2(WAIT + 1) : 1;

  word_t          mem [2**(AW-WW)];
  logic [CW-1:0]  cnt;   // wait states seen
  logic [AW-WW-1:0] idx; // word index
  logic           xfer;

  assign idx  = ls_adr[AW-1:WW];
  assign xfer = ls_req & ls_ack;

  // ack exactly WAIT+1 cycles after request seen
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt    <= '0;
      ls_ack <= 1'b0;
    end else begin
      ls_ack <= ls_req & ~ls_ack & (cnt == CW'(WAIT));
      if (ls_ack) cnt <= '0;
      else if (ls_req && cnt != CW'(WAIT)) cnt <= cnt + 1'b1;
    end
  end

  // storage, per lane write
  always_ff @(posedge clk) begin
    if (xfer && ls_wen) begin
      for (int i = 0; i < BW; i++) begin
        if (ls_ben[i]) mem[idx][8*i +: 8] <= ls_wdt[8*i +: 8];
      end
    end
    if (xfer && !ls_wen) ls_rdt <= mem[idx];  // valid next cycle
  end

endmodule

`default_nettype wire

// ==== source/lsu_issue.sv ====
/* load/store command sequencer
   four-phase host port, bus request control, read capture, error response */

`default_nettype none

module lsu_issue (
  input  logic             clk,
  input  logic             rst,
  // host command port
  input  logic             cmd_req,
  input  logic             cmd_we,
  input  lsu_pkg::f3_t     cmd_f3,
  input  lsu_pkg::word_t   cmd_adr,
  input  lsu_pkg::word_t   cmd_wdt,
  output logic             cmd_ack,
  output lsu_pkg::word_t   rsp_rdt,
  output logic             rsp_err,
  // alignment block
  output logic             en,
  output logic             we,
  output lsu_pkg::f3_t     f3,
  output lsu_pkg::word_t   adr,
  output lsu_pkg::word_t   wdt,
  input  logic             mal,
  input  logic             dly,
  input  lsu_pkg::word_t   rdt,
  // bus handshake, observed
  input  logic             ls_req,
  input  logic             ls_ack
);

  import lsu_pkg::*;

  issue_state_t state;
  logic         we_q;   // latched command
  f3_t          f3_q;
  adr_t         adr_q;
  word_t        wdt_q;
  logic         xfer;   // bus transfer this cycle

  assign xfer = ls_req & ls_ack;

  // idle shows the incoming command so mal is known at acceptance
  always_comb begin
    if (state == IDLE) begin
      we  = cmd_we;
      f3  = cmd_f3;
      adr = cmd_adr;
      wdt = cmd_wdt;
    end else begin
      we  = we_q;
      f3  = f3_q;
      adr = adr_q;
      wdt = wdt_q;
    end
  end

  assign en      = (state == BUS) || (state == RDWAIT);  // held through dly
  assign cmd_ack = (state == RESP);

  ////////////////////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= IDLE;
      rsp_err <= 1'b0;
    end else begin
      case (state)
        IDLE:
          if (cmd_req) begin
            rsp_err <= mal;
            state   <= mal ? RESP : BUS;  // rejected, no bus cycle
          end
        BUS:
          if (xfer) state <= we_q ? RESP : RDWAIT;
        RDWAIT:
          if (dly) state <= RESP;
        RESP:
          if (!cmd_req) state <= IDLE;  // host released
        default: state <= IDLE;
      endcase
    end
  end

  // command and response payload
  always_ff @(posedge clk) begin
    if (state == IDLE && cmd_req) begin
      we_q    <= cmd_we;
      f3_q    <= cmd_f3;
      adr_q   <= cmd_adr;
      wdt_q   <= cmd_wdt;
      rsp_rdt <= '0;  // zero for errors and stores
    end else if (state == RDWAIT && dly) begin
      rsp_rdt <= rdt;  // extended load data
    end
  end

endmodule

`default_nettype wire

// ==== source/lsu_align.sv ====
/* load/store alignment block
   misalignment check, byte lanes for writes, read extraction and extension */

`default_nettype none

`include "lsu_params.svh"

module lsu_align (
  input  logic                  clk,
  input  logic                  rst,
  // access from the sequencer
  input  logic                  en,      // access active
  input  logic                  we,      // store
  input  lsu_pkg::f3_t          f3,
  input  lsu_pkg::word_t        adr,     // byte address
  input  lsu_pkg::word_t        wdt,     // store data, right aligned
  output lsu_pkg::word_t        rdt,     // load data, extended
  output logic                  mal,     // misaligned or illegal
  output logic                  dly,     // read data valid
  // data bus
  output logic                  ls_req,
  output logic                  ls_wen,
  output logic [`LSU_AW-1:0]    ls_adr,
  output lsu_pkg::ben_t         ls_ben,
  output lsu_pkg::word_t        ls_wdt,
  input  lsu_pkg::word_t        ls_rdt,
  input  logic                  ls_ack
);

  import lsu_pkg::*;

  localparam int unsigned WW = $clog2(`LSU_XLEN/8);  // byte offset bits

  logic [WW-1:0] ofs;  // byte offset in word

  assign ofs = adr[WW-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // bus control
  ////////////////////////////////////////////////////////////////////////////

  assign ls_req = en & ~dly;  // no re-request in read data cycle
  assign ls_wen = we;
  assign ls_adr = {adr[`LSU_AW-1:WW], WW'(0)};  // word aligned

  // misalignment, rv64 codes count as illegal
  always_comb begin
    if (we) begin
      case (f3)
        SB:      mal = 1'b0;
        SH:      mal = ofs[0];
        SW:      mal = |ofs;
        default: mal = 1'b1;  // SD and unused
      endcase
    end else begin
      case (f3)
        LB, LBU: mal = 1'b0;
        LH, LHU: mal = ofs[0];
        LW:      mal = |ofs;
        default: mal = 1'b1;  // LD, LWU, unused
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // write lanes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (we) begin
      case (f3)
        SB:      ls_ben = ben_t'(4'b0001 << ofs);
        SH:      ls_ben = ben_t'(4'b0011 << ofs);
        SW:      ls_ben = ben_t'(4'b1111);
        default: ls_ben = '0;
      endcase
    end else begin
      ls_ben = '1;  // reads fetch the whole word
    end
  end

  // mask then shift into lane
  always_comb begin
    case (f3)
      SB:      ls_wdt = (wdt & word_t'(8'hff))   << {ofs, 3'b000};
      SH:      ls_wdt = (wdt & word_t'(16'hffff)) << {ofs, 3'b000};
      SW:      ls_wdt = wdt;
      default: ls_wdt = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // read extraction
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : blk_rdt
    word_t tmp;
    tmp = ls_rdt >> {ofs, 3'b000};  // addressed lane to bit 0
    case (f3)
      LB:      rdt = word_t'($signed(tmp[7:0]));
      LH:      rdt = word_t'($signed(tmp[15:0]));
      LW:      rdt = tmp;
      LBU:     rdt = word_t'(tmp[7:0]);
      LHU:     rdt = word_t'(tmp[15:0]);
      default: rdt = '0;
    endcase
  end

  // high in the cycle after an acknowledged read
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dly <= 1'b0;
    end else begin
      dly <= ls_req & ls_ack & ~ls_wen;
    end
  end

endmodule

`default_nettype wire

// ==== source/lsu_pkg.sv ====
/* load/store unit package
   word, address, byte enable and funct3 types, funct3 codes, sequencer states */

`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

  typedef logic [`LSU_XLEN-1:0]   word_t;  // data word
  typedef logic [`LSU_XLEN-1:0]   adr_t;   // byte address, command side
  typedef logic [`LSU_XLEN/8-1:0] ben_t;   // one bit per byte lane
  typedef logic [2:0]             f3_t;    // funct3 access code

  // load codes
  localparam f3_t LB  = 3'b000;
  localparam f3_t LH  = 3'b001;
  localparam f3_t LW  = 3'b010;
  localparam f3_t LD  = 3'b011;  // rv64, rejected
  localparam f3_t LBU = 3'b100;
  localparam f3_t LHU = 3'b101;
  localparam f3_t LWU = 3'b110;  // rv64, rejected

  // store codes
  localparam f3_t SB  = 3'b000;
  localparam f3_t SH  = 3'b001;
  localparam f3_t SW  = 3'b010;
  localparam f3_t SD  = 3'b011;  // rv64, rejected

  // command sequencer
  typedef enum logic [1:0] {
    IDLE,    // waiting for cmd_req
    BUS,     // request on data bus
    RDWAIT,  // read data arrives
    RESP     // cmd_ack held
  } issue_state_t;

endpackage

`default_nettype wire

// ==== include/lsu_params.svh ====
/* load/store unit parameters
   data width, data memory size and default memory wait states */

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// data path
////////////////////////////////////////////////////////////////////////////

`define LSU_XLEN 32       // rv32 only

////////////////////////////////////////////////////////////////////////////
// data memory
////////////////////////////////////////////////////////////////////////////

`define LSU_AW 10         // byte address bits, 1 KiB
`define LSU_DMEM_WAIT 1   // idle cycles before ack

`endif
